// File: rtl/memoryGamePkg.sv
/* Shared sizes, timer and round limits, the fixed button sequence
   and the controller state encoding for the memory game */

package memoryGamePkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int StepWidth      = 4;
    localparam int SequenceLength = 16;
    localparam int ShortGameRounds = 4;

    // ------------------------------------------------------------------------
    // Timing, in clock cycles
    // ------------------------------------------------------------------------
    // Cycles a step stays in waitShow
    localparam int ShowCycles     = 4;
    // Time allowed for one press
    localparam int LongPlayLimit  = 40;
    localparam int ShortPlayLimit = 16;
    localparam int TimerWidth     = 6;

    // ------------------------------------------------------------------------
    // Game sequence, one-hot button codes
    // ------------------------------------------------------------------------
    localparam logic [3:0] SequenceTable [SequenceLength] = '{
        4'b0001, 4'b0100, 4'b0010, 4'b1000,
        4'b0100, 4'b0001, 4'b1000, 4'b0010,
        4'b0010, 4'b0100, 4'b0001, 4'b0001,
        4'b1000, 4'b0100, 4'b0010, 4'b1000
    };

    // ------------------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        idle        = 4'h0,
        initGame    = 4'h1,
        startRound  = 4'h2,
        showStep    = 4'h3,
        waitShow    = 4'h4,
        nextShow    = 4'h5,
        startPlay   = 4'h6,
        waitPlay    = 4'h7,
        storePlay   = 4'h8,
        comparePlay = 4'h9,
        nextPlay    = 4'hA,
        nextRound   = 4'hB,
        gameWon     = 4'hC,
        gameLost    = 4'hD,
        gameTimeout = 4'hE
    } gameStateT;

endpackage

// File: rtl/levelConfig.sv
/* Game level register: round count and play time limit, fixed at start */

`timescale 1ns/1ps

module levelConfig import memoryGamePkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  latchLevel,
    input  logic                  longGame,
    input  logic                  shortTime,
    output logic [StepWidth-1:0]  lastRound,
    output logic [TimerWidth-1:0] playLimit
);

    logic longGameReg;
    logic shortTimeReg;

    // Level bits only change when a new game starts
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            longGameReg  <= 1'b0;
            shortTimeReg <= 1'b0;
        end else if (latchLevel) begin
            longGameReg  <= longGame;
            shortTimeReg <= shortTime;
        end
    end

    // Last round index
    assign lastRound = longGameReg ? StepWidth'(SequenceLength - 1)
                                   : StepWidth'(ShortGameRounds - 1);

    // Cycles allowed per press
    assign playLimit = shortTimeReg ? TimerWidth'(ShortPlayLimit)
                                    : TimerWidth'(LongPlayLimit);

endmodule

// File: rtl/gameController.sv
/* Moore control unit for the memory game: show, play, compare
   and end states, with datapath strobes decoded from the state */

`timescale 1ns/1ps

module gameController import memoryGamePkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,

    // Conditions from the datapath
    input  logic      stepEqualsRound,
    input  logic      showDone,
    input  logic      playTimeout,
    input  logic      playMade,
    input  logic      playCorrect,
    input  logic      lastRoundDone,

    // Datapath strobes
    output logic      clearStep,
    output logic      countStep,
    output logic      clearRound,
    output logic      countRound,
    output logic      clearShow,
    output logic      countShow,
    output logic      clearPlayTimer,
    output logic      countPlayTimer,
    output logic      storeButtons,
    output logic      clearButtons,
    output logic      latchLevel,
    output logic      showActive,

    // Game status
    output logic      playerTurn,
    output logic      won,
    output logic      lost,
    output logic      timedOut,
    output logic      done,
    output gameStateT state
);

    gameStateT nextState;

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            idle:        nextState = start ? initGame : idle;
            initGame:    nextState = startRound;
            startRound:  nextState = showStep;
            // Last step of the round skips the wait
            showStep:    nextState = stepEqualsRound ? startPlay : waitShow;
            waitShow:    nextState = showDone ? nextShow : waitShow;
            nextShow:    nextState = showStep;
            startPlay:   nextState = waitPlay;
            waitPlay: begin
                if (playTimeout) begin
                    nextState = gameTimeout;
                end else if (playMade) begin
                    nextState = storePlay;
                end
            end
            storePlay:   nextState = comparePlay;
            comparePlay: begin
                if (!playCorrect) begin
                    nextState = gameLost;
                end else if (!stepEqualsRound) begin
                    nextState = nextPlay;
                end else begin
                    nextState = lastRoundDone ? gameWon : nextRound;
                end
            end
            nextPlay:    nextState = waitPlay;
            nextRound:   nextState = startRound;
            gameWon,
            gameLost,
            gameTimeout: nextState = start ? initGame : state;
            default:     nextState = idle;
        endcase
    end

    // ------------------------------------------------------------------------
    // Moore outputs
    // ------------------------------------------------------------------------
    assign latchLevel     = state == initGame;
    assign clearRound     = state == initGame;
    assign clearStep      = state == startRound || state == startPlay;
    assign countStep      = state == nextShow || state == nextPlay;
    assign countRound     = state == nextRound;
    assign clearShow      = state == showStep;
    assign countShow      = state == waitShow;
    assign clearPlayTimer = state == startPlay || state == nextPlay;
    assign countPlayTimer = state == waitPlay;
    assign storeButtons   = state == storePlay;
    assign clearButtons   = state == initGame || state == startPlay;

    assign showActive = state == showStep || state == waitShow || state == nextShow;
    assign playerTurn = state == waitPlay;
    assign won        = state == gameWon;
    assign lost       = state == gameLost;
    assign timedOut   = state == gameTimeout;
    assign done       = won || lost || timedOut;

    // A press made before the player turn never counts
    assert property (@(posedge clock) disable iff (reset) state == startPlay |=> !playMade);

endmodule

// File: rtl/gameDatapath.sv
/* Memory game datapath: step and round counters, show and play timers,
   button press detection, play register and compare logic */

`timescale 1ns/1ps

module gameDatapath import memoryGamePkg::*; (
    input  logic                  clock,
    input  logic                  reset,

    // Strobes from the controller
    input  logic                  clearStep,
    input  logic                  countStep,
    input  logic                  clearRound,
    input  logic                  countRound,
    input  logic                  clearShow,
    input  logic                  countShow,
    input  logic                  clearPlayTimer,
    input  logic                  countPlayTimer,
    input  logic                  storeButtons,
    input  logic                  clearButtons,
    input  logic                  showActive,

    input  logic [3:0]            buttons,
    input  logic [StepWidth-1:0]  lastRound,
    input  logic [TimerWidth-1:0] playLimit,

    output logic [3:0]            leds,
    output logic                  stepEqualsRound,
    output logic                  showDone,
    output logic                  playTimeout,
    output logic                  playMade,
    output logic                  playCorrect,
    output logic                  lastRoundDone
);

    logic [StepWidth-1:0]  stepIndex;
    logic [StepWidth-1:0]  roundIndex;
    logic [TimerWidth-1:0] showCount;
    logic [TimerWidth-1:0] playTimer;
    logic [3:0]            prevButtons;
    logic [3:0]            pressCode;
    logic [3:0]            playReg;
    logic [3:0]            newPress;

    // ------------------------------------------------------------------------
    // Counters and timers
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stepIndex  <= '0;
            roundIndex <= '0;
            showCount  <= '0;
            playTimer  <= '0;
        end else begin
            if (clearStep) begin
                stepIndex <= '0;
            end else if (countStep) begin
                stepIndex <= stepIndex + 1'b1;
            end
            if (clearRound) begin
                roundIndex <= '0;
            end else if (countRound) begin
                roundIndex <= roundIndex + 1'b1;
            end
            if (clearShow) begin
                showCount <= '0;
            end else if (countShow) begin
                showCount <= showCount + 1'b1;
            end
            if (clearPlayTimer) begin
                playTimer <= '0;
            end else if (countPlayTimer) begin
                playTimer <= playTimer + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Press detection and play register
    // ------------------------------------------------------------------------
    // Rising edge on any button
    assign newPress = buttons & ~prevButtons;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prevButtons <= '0;
            pressCode   <= '0;
            playReg     <= '0;
        end else begin
            prevButtons <= buttons;
            // First press wins until it is consumed
            if (clearButtons || storeButtons) begin
                pressCode <= '0;
            end else if (pressCode == 4'b0000) begin
                pressCode <= newPress;
            end
            if (clearButtons) begin
                playReg <= '0;
            end else if (storeButtons) begin
                playReg <= pressCode;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Conditions and display
    // ------------------------------------------------------------------------
    assign stepEqualsRound = stepIndex == roundIndex;
    assign lastRoundDone   = roundIndex == lastRound;
    assign showDone        = showCount == TimerWidth'(ShowCycles - 1);
    assign playTimeout     = playTimer == playLimit;
    assign playMade        = |pressCode;
    assign playCorrect     = playReg == SequenceTable[stepIndex];
    assign leds            = showActive ? SequenceTable[stepIndex] : 4'b0000;

    // Stored play is a single button or nothing
    assert property (@(posedge clock) disable iff (reset) $onehot0(playReg));

endmodule

// File: rtl/memoryGameTop.sv
/* Memory game top level: controller, datapath and level configuration */

`timescale 1ns/1ps

module memoryGameTop import memoryGamePkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  logic       longGame,
    input  logic       shortTime,
    input  logic [3:0] buttons,
    output logic [3:0] leds,
    output logic       playerTurn,
    output logic       won,
    output logic       lost,
    output logic       timedOut,
    output logic       done,
    output gameStateT  stateDebug
);

    // ------------------------------------------------------------------------
    // Strobes and conditions
    // ------------------------------------------------------------------------
    logic clearStep;
    logic countStep;
    logic clearRound;
    logic countRound;
    logic clearShow;
    logic countShow;
    logic clearPlayTimer;
    logic countPlayTimer;
    logic storeButtons;
    logic clearButtons;
    logic latchLevel;
    logic showActive;

    logic stepEqualsRound;
    logic showDone;
    logic playTimeout;
    logic playMade;
    logic playCorrect;
    logic lastRoundDone;

    logic [StepWidth-1:0]  lastRound;
    logic [TimerWidth-1:0] playLimit;

    gameController gameController_inst (
        .clock, .reset, .start,
        .stepEqualsRound, .showDone, .playTimeout, .playMade, .playCorrect, .lastRoundDone,
        .clearStep, .countStep, .clearRound, .countRound, .clearShow, .countShow,
        .clearPlayTimer, .countPlayTimer, .storeButtons, .clearButtons, .latchLevel,
        .showActive, .playerTurn, .won, .lost, .timedOut, .done,
        .state (stateDebug)
    );

    gameDatapath gameDatapath_inst (
        .clock, .reset,
        .clearStep, .countStep, .clearRound, .countRound, .clearShow, .countShow,
        .clearPlayTimer, .countPlayTimer, .storeButtons, .clearButtons, .showActive,
        .buttons, .lastRound, .playLimit,
        .leds, .stepEqualsRound, .showDone, .playTimeout, .playMade, .playCorrect,
        .lastRoundDone
    );

    levelConfig levelConfig_inst (
        .clock, .reset, .latchLevel, .longGame, .shortTime,
        .lastRound, .playLimit
    );

endmodule

// File: verif/memoryGameTb.sv
/* Table-driven testbench for the memory game: plays whole games and checks
   the shown sequence, LEDs, end states and outcome flags */

`timescale 1ns/1ps

module memoryGameTb import memoryGamePkg::*; ();

    typedef enum logic [1:0] {noFault, wrongButton, noPress} faultT;

    localparam int NumGames     = 6;
    localparam int StepLimit    = ShowCycles + 8;
    localparam int CompareLimit = 6;
    // Cycles past the play limit by which a game has ended
    localparam int EndMargin    = 8;

    // ------------------------------------------------------------------------
    // Stimulus table, one entry per game
    // ------------------------------------------------------------------------
    localparam logic      LongCol       [NumGames] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    localparam logic      ShortCol      [NumGames] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
    localparam int        FaultRoundCol [NumGames] = '{0, 2, 1, 0, 0, 5};
    localparam faultT     FaultCol      [NumGames] = '{noFault, wrongButton, noPress,
                                                       noPress, noFault, wrongButton};
    localparam gameStateT ExpectCol     [NumGames] = '{gameWon, gameLost, gameTimeout,
                                                       gameTimeout, gameWon, gameLost};

    logic        clock = 1'b0;
    logic        reset;
    logic        start;
    logic        longGame;
    logic        shortTime;
    logic [3:0]  buttons;
    logic [3:0]  leds;
    logic        playerTurn;
    logic        won;
    logic        lost;
    logic        timedOut;
    logic        done;
    gameStateT   stateDebug;

    int          ledErrors;
    int          stateErrors;
    int          flagErrors;
    int          timeoutErrors;

    memoryGameTop memoryGameTop_inst (
        .clock, .reset, .start, .longGame, .shortTime, .buttons,
        .leds, .playerTurn, .won, .lost, .timedOut, .done, .stateDebug
    );

    always #5 clock = ~clock;

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic checkLeds(input logic [3:0] expected);
        if (leds !== expected) begin
            ledErrors++;
            $display("error at %0t ns: leds %b, expected %b", $time, leds, expected);
        end
    endtask

    task automatic checkState(input gameStateT expected);
        if (stateDebug !== expected) begin
            stateErrors++;
            $display("error at %0t ns: state %s, expected %s", $time,
                     stateDebug.name(), expected.name());
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            flagErrors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // ------------------------------------------------------------------------
    // Waits
    // ------------------------------------------------------------------------
    task automatic reportTimeout(input string what);
        timeoutErrors++;
        $display("Timeout: the %s never came", what);
    endtask

    // Optionally flags any extra lit step while waiting
    task automatic waitState(input gameStateT target, input int limit, input string what,
                             input bit forbidShow);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (forbidShow && stateDebug == showStep) begin
                stateErrors++;
                $display("error at %0t ns: extra step shown before the player turn", $time);
            end
        end while (stateDebug != target && cycles < limit);
        if (stateDebug != target) begin
            reportTimeout(what);
        end
    endtask

    task automatic waitDone(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!done && cycles < limit);
        if (!done) begin
            reportTimeout("end of the game");
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic pulseStart();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic pressButton(input logic [3:0] code);
        @(posedge clock);
        buttons <= code;
        @(posedge clock);
        buttons <= 4'b0000;
    endtask

    // Random pick among the three codes that are not the right one
    function automatic logic [3:0] pickWrongCode(input logic [3:0] right);
        logic [3:0] others [3];
        int         count;
        int         bitIndex;
        count = 0;
        for (bitIndex = 0; bitIndex < 4; bitIndex++) begin
            if (right != (4'b0001 << bitIndex) && count < 3) begin
                others[count] = 4'b0001 << bitIndex;
                count++;
            end
        end
        return others[$urandom % 3];
    endfunction

    task automatic playGame(input int row);
        int  rounds;
        int  round;
        int  step;
        int  endLimit;
        bit  ended;
        rounds   = LongCol[row] ? SequenceLength : ShortGameRounds;
        endLimit = (ShortCol[row] ? ShortPlayLimit : LongPlayLimit) + EndMargin;
        ended    = 1'b0;
        @(posedge clock);
        longGame  <= LongCol[row];
        shortTime <= ShortCol[row];
        pulseStart();
        for (round = 0; round < rounds && !ended; round++) begin
            for (step = 0; step <= round; step++) begin
                waitState(showStep, StepLimit, "lit step", 1'b0);
                if (timeoutErrors != 0) begin
                    return;
                end
                checkLeds(SequenceTable[step]);
            end
            for (step = 0; step <= round && !ended; step++) begin
                waitState(waitPlay, StepLimit, "player turn", 1'b1);
                if (timeoutErrors != 0) begin
                    return;
                end
                checkFlag("playerTurn", playerTurn, 1'b1);
                checkLeds(4'b0000);
                // Level input changes mid-game must not matter
                if (round == 1 && step == 0) begin
                    @(posedge clock);
                    longGame <= ~LongCol[row];
                end
                if (round == FaultRoundCol[row] && FaultCol[row] == wrongButton) begin
                    pressButton(pickWrongCode(SequenceTable[step]));
                    ended = 1'b1;
                end else if (round == FaultRoundCol[row] && FaultCol[row] == noPress) begin
                    ended = 1'b1;
                end else begin
                    pressButton(SequenceTable[step]);
                    waitState(comparePlay, CompareLimit, "compare of a press", 1'b0);
                    if (timeoutErrors != 0) begin
                        return;
                    end
                end
            end
        end
        waitDone(endLimit);
        if (timeoutErrors != 0) begin
            return;
        end
        checkState(ExpectCol[row]);
        checkFlag("won", won, ExpectCol[row] == gameWon);
        checkFlag("lost", lost, ExpectCol[row] == gameLost);
        checkFlag("timedOut", timedOut, ExpectCol[row] == gameTimeout);
        checkFlag("done", done, 1'b1);
        checkFlag("playerTurn", playerTurn, 1'b0);
        checkLeds(4'b0000);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h6b428415));
        ledErrors     = 0;
        stateErrors   = 0;
        flagErrors    = 0;
        timeoutErrors = 0;
        reset         = 1'b1;
        start         = 1'b0;
        longGame      = 1'b0;
        shortTime     = 1'b0;
        buttons       = 4'b0000;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        checkState(idle);
        checkLeds(4'b0000);
        checkFlag("playerTurn", playerTurn, 1'b0);
        checkFlag("won", won, 1'b0);
        checkFlag("lost", lost, 1'b0);
        checkFlag("timedOut", timedOut, 1'b0);
        checkFlag("done", done, 1'b0);
        // Later games start from the end state of the one before
        for (int row = 0; row < NumGames && timeoutErrors == 0; row++) begin
            playGame(row);
        end
        $display("Errors: leds %0d, state %0d, flags %0d, timeouts %0d",
                 ledErrors, stateErrors, flagErrors, timeoutErrors);
        if (ledErrors + stateErrors + flagErrors + timeoutErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/memoryGamePkg.sv
rtl/levelConfig.sv
rtl/gameController.sv
rtl/gameDatapath.sv
rtl/memoryGameTop.sv
verif/memoryGameTb.sv
